// File: source/adcCapture.sv
`timescale 1ns/100ps
`default_nettype none

module adcCapture import adcPkg::*; #(
  // Converter resolution, 10, 14 or 16 bits
  parameter int ADC_WIDTH = DEFAULT_ADC_WIDTH,
  // Start-up edges whose samples are thrown away
  parameter int SETTLE_CYCLES = DEFAULT_SETTLE_CYCLES
) (
  input logic ADC_CLK_IN,
  input logic DSP_RST_IN,
  // Raw offset-binary samples, new pair every clock
  input logic [ADC_WIDTH-1:0] adcDataI,
  input logic [ADC_WIDTH-1:0] adcDataQ,
  sampleIf.source samples
);

  // Counter only has to reach SETTLE_CYCLES-1
  localparam int COUNT_WIDTH = (SETTLE_CYCLES > 1) ? $clog2(SETTLE_CYCLES) : 1;
  // Count value on the last settling edge
  localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(SETTLE_CYCLES - 1);

  captureState_t captureState;
  logic [COUNT_WIDTH-1:0] settleCount;

  // Settling sequencer
  // Stays in settling for SETTLE_CYCLES edges after reset release
  always_ff @(posedge ADC_CLK_IN or posedge DSP_RST_IN) begin
    if (DSP_RST_IN) begin
      captureState <= settling;
      settleCount <= '0;
    end else begin
      if (captureState == settling) begin
        settleCount <= settleCount + COUNT_WIDTH'(1);
        // Edge number SETTLE_CYCLES moves to running
        if (settleCount == LAST_COUNT) begin
          captureState <= running;
        end
      end
    end
  end

  // Input register for both channels
  // Offset binary to two's complement by flipping the sign bit
  // The pair taken at an edge is on the interface for the next cycle
  always_ff @(posedge ADC_CLK_IN) begin
    samples.iSample <= {~adcDataI[ADC_WIDTH-1], adcDataI[ADC_WIDTH-2:0]};
    samples.qSample <= {~adcDataQ[ADC_WIDTH-1], adcDataQ[ADC_WIDTH-2:0]};
  end

  // One strobe per running cycle
  // First strobe carries the pair taken at edge SETTLE_CYCLES
  // The buffer alone decides whether a pair is kept or dropped
  assign samples.sampleWrite = (captureState == running);

endmodule

`default_nettype wire

// File: source/adcFrontEnd.sv
`timescale 1ns/100ps
`default_nettype none

module adcFrontEnd import adcPkg::*; #(
  // Converter resolution, 10, 14 or 16 bits
  parameter int ADC_WIDTH = DEFAULT_ADC_WIDTH,
  // Buffer holds 2**FIFO_DEPTH_LOG2 pairs
  parameter int FIFO_DEPTH_LOG2 = DEFAULT_FIFO_DEPTH_LOG2,
  // Start-up edges whose samples are discarded
  parameter int SETTLE_CYCLES = DEFAULT_SETTLE_CYCLES
) (
  input logic ADC_CLK_IN,
  input logic DSP_RST_IN,
  // Raw offset-binary converter data
  input logic [ADC_WIDTH-1:0] adcDataI,
  input logic [ADC_WIDTH-1:0] adcDataQ,
  // DSP pull level
  input logic dspReadEnable,
  // Two's complement pair towards the DSP
  output logic [ADC_WIDTH-1:0] sampleI,
  output logic [ADC_WIDTH-1:0] sampleQ,
  output logic sampleValid,
  output logic overflow
);

  // Link between capture and buffer
  sampleIf #(
    .ADC_WIDTH(ADC_WIDTH)
  ) samples ();

  // Input register, format conversion and start-up settling
  adcCapture #(
    .ADC_WIDTH(ADC_WIDTH),
    .SETTLE_CYCLES(SETTLE_CYCLES)
  ) capture0 (
    .ADC_CLK_IN(ADC_CLK_IN),
    .DSP_RST_IN(DSP_RST_IN),
    .adcDataI(adcDataI),
    .adcDataQ(adcDataQ),
    .samples(samples.source)
  );

  // Absorbs DSP back-pressure and flags lost pairs
  sampleFifo #(
    .ADC_WIDTH(ADC_WIDTH),
    .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
  ) fifo0 (
    .ADC_CLK_IN(ADC_CLK_IN),
    .DSP_RST_IN(DSP_RST_IN),
    .samples(samples.sink),
    .dspReadEnable(dspReadEnable),
    .sampleI(sampleI),
    .sampleQ(sampleQ),
    .sampleValid(sampleValid),
    .overflow(overflow)
  );

endmodule

`default_nettype wire

// File: source/adcPkg.sv
`default_nettype none

package adcPkg;

  // Capture block state
  // Settling discards samples while the converter starts up
  typedef enum logic {
    settling,
    running
  } captureState_t;

  // Converter resolution in bits
  // Legal values are 10, 14 and 16
  localparam int DEFAULT_ADC_WIDTH = 10;

  // Log2 of the sample-pair buffer depth
  // 4 gives room for 16 pairs
  localparam int DEFAULT_FIFO_DEPTH_LOG2 = 4;

  // Start-up edges whose samples are discarded
  localparam int DEFAULT_SETTLE_CYCLES = 16;

endpackage

`default_nettype wire

// File: source/sampleFifo.sv
`timescale 1ns/100ps
`default_nettype none

module sampleFifo import adcPkg::*; #(
  // Width of each channel sample
  parameter int ADC_WIDTH = DEFAULT_ADC_WIDTH,
  // Buffer holds 2**FIFO_DEPTH_LOG2 pairs
  parameter int FIFO_DEPTH_LOG2 = DEFAULT_FIFO_DEPTH_LOG2
) (
  input logic ADC_CLK_IN,
  input logic DSP_RST_IN,
  sampleIf.sink samples,
  // DSP holds this high to pull pairs
  input logic dspReadEnable,
  output logic [ADC_WIDTH-1:0] sampleI,
  output logic [ADC_WIDTH-1:0] sampleQ,
  output logic sampleValid,
  // Sticky until reset
  output logic overflow
);

  localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;
  localparam int PAIR_WIDTH = 2 * ADC_WIDTH;

  // Pair storage, Q in the upper half
  logic [PAIR_WIDTH-1:0] pairMem [DEPTH];

  // Pointers carry one extra wrap bit to tell full from empty
  logic [FIFO_DEPTH_LOG2:0] wrPtr;
  logic [FIFO_DEPTH_LOG2:0] rdPtr;

  logic fifoEmpty;
  logic writeAccept;
  logic readAccept;

  // Registered read port
  logic [PAIR_WIDTH-1:0] readPair;
  logic readDone;

  // Equal addresses with different wrap bits mean full
  assign samples.bufferFull =
    (wrPtr[FIFO_DEPTH_LOG2] != rdPtr[FIFO_DEPTH_LOG2]) &&
    (wrPtr[FIFO_DEPTH_LOG2-1:0] == rdPtr[FIFO_DEPTH_LOG2-1:0]);
  assign fifoEmpty = (wrPtr == rdPtr);

  // Pairs offered while full are lost, stored data is never overwritten
  assign writeAccept = samples.sampleWrite && !samples.bufferFull;
  // Read on every cycle the DSP asks and data is present
  assign readAccept = dspReadEnable && !fifoEmpty;

  // Pointer and flag control
  always_ff @(posedge ADC_CLK_IN or posedge DSP_RST_IN) begin
    if (DSP_RST_IN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      readDone <= 1'b0;
      overflow <= 1'b0;
    end else begin
      if (writeAccept) begin
        wrPtr <= wrPtr + (FIFO_DEPTH_LOG2 + 1)'(1);
      end
      if (readAccept) begin
        rdPtr <= rdPtr + (FIFO_DEPTH_LOG2 + 1)'(1);
      end
      // Marks the pair now sitting in readPair
      readDone <= readAccept;
      // Lost pair, held high until the next reset
      if (samples.sampleWrite && samples.bufferFull) begin
        overflow <= 1'b1;
      end
    end
  end

  // Storage write
  always_ff @(posedge ADC_CLK_IN) begin
    if (writeAccept) begin
      pairMem[wrPtr[FIFO_DEPTH_LOG2-1:0]] <= {samples.qSample, samples.iSample};
    end
  end

  // Read stage
  // A pair written at edge n is fetched here at edge n+1 at the earliest
  always_ff @(posedge ADC_CLK_IN) begin
    if (readAccept) begin
      readPair <= pairMem[rdPtr[FIFO_DEPTH_LOG2-1:0]];
    end
  end

  // Output stage to the DSP
  // Data and valid appear one cycle after the read
  always_ff @(posedge ADC_CLK_IN) begin
    if (readDone) begin
      sampleI <= readPair[ADC_WIDTH-1:0];
      sampleQ <= readPair[PAIR_WIDTH-1:ADC_WIDTH];
    end
  end

  // Valid is a single-cycle strobe per pair
  always_ff @(posedge ADC_CLK_IN or posedge DSP_RST_IN) begin
    if (DSP_RST_IN) begin
      sampleValid <= 1'b0;
    end else begin
      sampleValid <= readDone;
    end
  end

endmodule

`default_nettype wire

// File: source/sampleIf.sv
`timescale 1ns/100ps
`default_nettype none

// Converted I/Q pair travelling from the capture block into the buffer
interface sampleIf import adcPkg::*; #(
  // Width of each channel sample
  parameter int ADC_WIDTH = DEFAULT_ADC_WIDTH
);

  // Two's complement samples, both channels taken on the same edge
  logic [ADC_WIDTH-1:0] iSample;
  logic [ADC_WIDTH-1:0] qSample;

  // High in every running cycle, one pair per strobe
  logic sampleWrite;

  // Buffer has no free slot
  // A pair offered now is lost
  logic bufferFull;

  // Capture side
  modport source (
    output iSample,
    output qSample,
    output sampleWrite,
    input  bufferFull
  );

  // Buffer side
  modport sink (
    input  iSample,
    input  qSample,
    input  sampleWrite,
    output bufferFull
  );

endinterface

`default_nettype wire

// File: test/adcFrontEndTb.sv
`timescale 1ns/100ps
`default_nettype none

module adcFrontEndTb import adcPkg::*; ();

  localparam int ADC_WIDTH = DEFAULT_ADC_WIDTH;
  localparam int FIFO_DEPTH_LOG2 = DEFAULT_FIFO_DEPTH_LOG2;
  localparam int SETTLE_CYCLES = DEFAULT_SETTLE_CYCLES;
  localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;
  localparam logic [ADC_WIDTH-1:0] SIGN_BIT = {1'b1, {(ADC_WIDTH-1){1'b0}}};

  // Test lengths in clock cycles
  localparam int RESET_LEN = 10;
  localparam int FIRST_VALID_LIMIT = 8;
  localparam int STREAM_LEN = 40;
  localparam int SHORT_STALL = DEPTH / 2 + 2;
  localparam int RESUME_LEN = 3 * DEPTH;
  localparam int LONG_STALL = 3 * DEPTH;
  localparam int RANDOM_LEN = 200;
  localparam int TEST_LEN = RESET_LEN + SETTLE_CYCLES + FIRST_VALID_LIMIT + STREAM_LEN +
                            SHORT_STALL + RESUME_LEN + LONG_STALL + RESUME_LEN + RANDOM_LEN;
  localparam int TIMEOUT_CYCLES = 2 * TEST_LEN;

  logic ADC_CLK_IN;
  logic DSP_RST_IN;
  logic [ADC_WIDTH-1:0] adcDataI;
  logic [ADC_WIDTH-1:0] adcDataQ;
  logic dspReadEnable;
  logic [ADC_WIDTH-1:0] sampleI;
  logic [ADC_WIDTH-1:0] sampleQ;
  logic sampleValid;
  logic overflow;

  // Reference model state with Q in the upper half of a pair
  logic [2*ADC_WIDTH-1:0] pairQueue [$];
  logic offerValid = 1'b0;
  logic [2*ADC_WIDTH-1:0] offerPair;
  logic readPending = 1'b0;
  logic [2*ADC_WIDTH-1:0] readPair;
  logic expValid = 1'b0;
  logic expOverflow = 1'b0;
  logic [ADC_WIDTH-1:0] expI;
  logic [ADC_WIDTH-1:0] expQ;
  int edgeNum = 0;
  int cycleCount = 0;

  // Ramp stimulus and in-order tracking on the I channel
  logic [ADC_WIDTH-1:0] rampValue = '0;
  logic [ADC_WIDTH-1:0] lastRaw;
  int seedResult;

  clockGen #(
    .HALF_PERIOD(10),
    .RESET_CYCLES(8)
  ) clock0 (
    .adcClk(ADC_CLK_IN),
    .dspRst(DSP_RST_IN)
  );

  adcFrontEnd #(
    .ADC_WIDTH(ADC_WIDTH),
    .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2),
    .SETTLE_CYCLES(SETTLE_CYCLES)
  ) dut0 (
    .ADC_CLK_IN(ADC_CLK_IN),
    .DSP_RST_IN(DSP_RST_IN),
    .adcDataI(adcDataI),
    .adcDataQ(adcDataQ),
    .dspReadEnable(dspReadEnable),
    .sampleI(sampleI),
    .sampleQ(sampleQ),
    .sampleValid(sampleValid),
    .overflow(overflow)
  );

  // Offset binary and two's complement differ only in the sign bit
  function automatic logic [ADC_WIDTH-1:0] flipSign(input logic [ADC_WIDTH-1:0] value);
    return value ^ SIGN_BIT;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
      $display("Test FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic stopRun(input string reason);
    $display("Error at %0t ns: %s", $time, reason);
    $display("Test FAILED");
    $fatal(1, "%s", reason);
  endtask

  // One clock cycle with new inputs on the rising edge and return on the falling edge
  task automatic driveCycle(input logic readEnable, input logic [ADC_WIDTH-1:0] iValue,
                            input logic [ADC_WIDTH-1:0] qValue);
    @(posedge ADC_CLK_IN);
    adcDataI <= iValue;
    adcDataQ <= qValue;
    dspReadEnable <= readEnable;
    @(negedge ADC_CLK_IN);
  endtask

  // Q carries the inverted ramp so a swapped pair shows up
  task automatic rampCycle(input logic readEnable);
    driveCycle(readEnable, rampValue, ~rampValue);
    rampValue = rampValue + 1'b1;
  endtask

  // A valid output must be the next ramp step
  task automatic checkNextInOrder();
    logic [ADC_WIDTH-1:0] nextRaw;
    if (sampleValid) begin
      nextRaw = lastRaw + 1'b1;
      checkValue("sampleI", flipSign(nextRaw), sampleI);
      checkValue("sampleQ", flipSign(~nextRaw), sampleQ);
      lastRaw = nextRaw;
    end
  endtask

  // Model step per edge sees the inputs as they were before the edge
  always @(posedge ADC_CLK_IN) begin : modelStep
    logic wasFull;
    logic wasEmpty;
    cycleCount = cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles with tests still running", cycleCount);
      $display("Test FAILED");
      $fatal(1, "Timeout");
    end
    if (DSP_RST_IN) begin
      pairQueue.delete();
      offerValid = 1'b0;
      readPending = 1'b0;
      expValid = 1'b0;
      expOverflow = 1'b0;
      edgeNum = 0;
    end else begin
      edgeNum = edgeNum + 1;
      // Output follows the read from the previous edge
      expValid = readPending;
      if (readPending) begin
        {expQ, expI} = readPair;
      end
      // Read and write both see the occupancy from before this edge
      wasFull = (pairQueue.size() == DEPTH);
      wasEmpty = (pairQueue.size() == 0);
      readPending = dspReadEnable && !wasEmpty;
      if (readPending) begin
        readPair = pairQueue.pop_front();
      end
      if (offerValid) begin
        if (wasFull) begin
          expOverflow = 1'b1;
        end else begin
          pairQueue.push_back(offerPair);
        end
      end
      // Pair present at edge SETTLE_CYCLES is the first one offered
      offerValid = (edgeNum >= SETTLE_CYCLES);
      offerPair = {flipSign(adcDataQ), flipSign(adcDataI)};
    end
  end

  // Compare on the falling edge where outputs are stable
  // Nothing is compared before the first rising edge has applied reset
  always @(negedge ADC_CLK_IN) begin
    if (cycleCount > 0) begin
      checkValue("sampleValid", expValid, sampleValid);
      checkValue("overflow", expOverflow, overflow);
      if (expValid) begin
        checkValue("sampleI", expI, sampleI);
        checkValue("sampleQ", expQ, sampleQ);
      end
    end
  end

  // Nothing leaves the front end during reset and settling
  task automatic checkSettling();
    while (DSP_RST_IN || edgeNum < SETTLE_CYCLES) begin
      rampCycle(1'b1);
      checkValue("sampleValid", 0, sampleValid);
      checkValue("overflow", 0, overflow);
    end
    if (dut0.capture0.captureState != running) begin
      stopRun("Capture block is not running after the settle period");
    end
  endtask

  // Empty FIFO with the DSP pulling one pair per cycle
  task automatic streamRamp();
    int waitCycles;
    // Pair present at edge SETTLE_CYCLES was driven two ramp steps back
    lastRaw = rampValue - ADC_WIDTH'(3);
    waitCycles = 0;
    while (sampleValid !== 1'b1) begin
      if (waitCycles == FIRST_VALID_LIMIT) begin
        stopRun("No sampleValid seen after the settle period");
      end
      rampCycle(1'b1);
      waitCycles++;
    end
    checkValue("firstValidEdge", SETTLE_CYCLES + 3, edgeNum);
    checkNextInOrder();
    repeat (STREAM_LEN) begin
      rampCycle(1'b1);
      checkValue("sampleValid", 1, sampleValid);
      checkNextInOrder();
    end
  endtask

  // Short stall fits in the buffer so nothing is lost
  task automatic backPressure();
    repeat (SHORT_STALL) begin
      rampCycle(1'b0);
      checkNextInOrder();
      checkValue("overflow", 0, overflow);
    end
    repeat (RESUME_LEN) begin
      rampCycle(1'b1);
      checkNextInOrder();
      checkValue("overflow", 0, overflow);
    end
  endtask

  // Long stall fills the buffer and newer pairs are dropped
  task automatic overflowStall();
    int resumeOutputs;
    repeat (LONG_STALL) begin
      rampCycle(1'b0);
      checkNextInOrder();
    end
    checkValue("overflow", 1, overflow);
    resumeOutputs = 0;
    repeat (RESUME_LEN) begin
      rampCycle(1'b1);
      checkValue("overflow", 1, overflow);
      // Only the pairs held at the stall continue the ramp
      if (sampleValid && resumeOutputs < DEPTH) begin
        checkNextInOrder();
        resumeOutputs++;
      end
    end
  endtask

  // Random data and random DSP pulls against the reference model
  task automatic randomTraffic();
    logic [ADC_WIDTH-1:0] iValue;
    logic [ADC_WIDTH-1:0] qValue;
    logic readEnable;
    repeat (RANDOM_LEN) begin
      iValue = ADC_WIDTH'($urandom);
      qValue = ADC_WIDTH'($urandom);
      readEnable = 1'($urandom % 2);
      driveCycle(readEnable, iValue, qValue);
    end
  endtask

  initial begin
    seedResult = $urandom(58491);
    adcDataI = '0;
    adcDataQ = '0;
    dspReadEnable = 1'b1;
    checkSettling();
    streamRamp();
    backPressure();
    overflowStall();
    randomTraffic();
    $display("Finished after %0d cycles", cycleCount);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen #(
  // Half of the 20 ns clock period
  parameter int HALF_PERIOD = 10,
  // Clock edges with reset held high
  parameter int RESET_CYCLES = 8
) (
  output logic adcClk,
  output logic dspRst
);

  // Free-running converter clock, low at time zero
  initial begin
    adcClk = 1'b0;
    forever #(HALF_PERIOD) adcClk = ~adcClk;
  end

  // Reset drops on a falling edge, away from the sampling edge
  initial begin
    dspRst = 1'b1;
    repeat (RESET_CYCLES) @(posedge adcClk);
    @(negedge adcClk);
    dspRst = 1'b0;
  end

endmodule

`default_nettype wire

// File: vlog.f
source/adcPkg.sv
source/sampleIf.sv
source/adcCapture.sv
source/sampleFifo.sv
source/adcFrontEnd.sv
test/clockGen.sv
test/adcFrontEndTb.sv
